//--- vdc_params.svh
/*
 * VDC video parameters
 * register file size, register index width and the blink half-periods
 * shared by the register file and the raster timing
 */

`ifndef VDC_PARAMS_SVH
`define VDC_PARAMS_SVH

// implemented registers R0..R37
`define VDC_REG_COUNT 38

// register index width, enough for R0..R63
`define VDC_ADDR_W 6

// slow blink, level toggles every 30 frames
`define VDC_BLINK_SLOW 30

// fast blink, level toggles every 16 frames
`define VDC_BLINK_FAST 16

`endif

//--- vdcRegPkg.sv
/*
 * VDC register-side types
 * register index and data widths, character cell dimension fields
 * and the indices of the registers the video path decodes
 */

`include "vdc_params.svh"

package vdcRegPkg;

   typedef logic [`VDC_ADDR_W-1:0] regIdxT;   // register number
   typedef logic [7:0]             regByteT;  // register contents
   typedef logic [4:0]             charDimT;  // char width/height minus one

   // decoded registers
   localparam regIdxT idxHt      = 6'd0;   // horizontal total
   localparam regIdxT idxHd      = 6'd1;   // horizontal displayed
   localparam regIdxT idxHp      = 6'd2;   // hsync position
   localparam regIdxT idxSync    = 6'd3;   // vsync width | hsync width
   localparam regIdxT idxVt      = 6'd4;   // vertical total
   localparam regIdxT idxVa      = 6'd5;   // vertical adjust
   localparam regIdxT idxVd      = 6'd6;   // vertical displayed
   localparam regIdxT idxVp      = 6'd7;   // vsync position
   localparam regIdxT idxCtv     = 6'd9;   // char total vertical
   localparam regIdxT idxCurMode = 6'd10;  // cursor mode in bits 6:5
   localparam regIdxT idxDispHi  = 6'd12;  // display start high
   localparam regIdxT idxDispLo  = 6'd13;  // display start low
   localparam regIdxT idxCurHi   = 6'd14;  // cursor position high
   localparam regIdxT idxCurLo   = 6'd15;  // cursor position low
   localparam regIdxT idxCharH   = 6'd22;  // char total horizontal | displayed
   localparam regIdxT idxColor   = 6'd26;  // fg | bg
   localparam regIdxT idxDeb     = 6'd34;  // display enable begin
   localparam regIdxT idxDee     = 6'd35;  // display enable end

endpackage

//--- vdcVideoPkg.sv
/*
 * VDC video-side types
 * pixel colour, screen memory address, raster counts and the
 * frame marker kinds
 */

package vdcVideoPkg;

   typedef logic [3:0]  rgbiT;     // red, green, blue, intensity
   typedef logic [15:0] scrAddrT;  // screen memory address
   typedef logic [7:0]  colCntT;   // character column
   typedef logic [7:0]  rowCntT;   // character row

   // kind of frame that starts with a newFrame pulse
   typedef enum logic [1:0] {
      FRAME_NONE   = 2'b00,  // no frame start this cycle
      FRAME_ODD    = 2'b01,  // interlaced odd field
      FRAME_EVEN   = 2'b10,  // interlaced even field
      FRAME_SINGLE = 2'b11   // progressive frame
   } frameKindT;

endpackage

//--- vdcRegFile.sv
/*
 * VDC register file
 * CPU written registers with combinational readback, field decode for
 * the video path and a restart pulse after a timing register write
 */

`timescale 1ns/1ps
`include "vdc_params.svh"

module vdcRegFile
   import vdcRegPkg::*;
   import vdcVideoPkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       regWr,
   input  regIdxT     regIdx,
   input  regByteT    regWrData,
   output regByteT    regRdData,
   output regByteT    ht, hd, hp, vt, vd, vp, deb, dee,
   output logic [3:0] hw, vw, cth, fg, bg,
   output charDimT    va, ctv,
   output scrAddrT    dispStart, cursorPos,
   output logic [1:0] cursorMode,
   output logic       init
);

   regByteT regs [`VDC_REG_COUNT];

   // power-on values of the standard 80 column setup
   function automatic regByteT resetVal(input int idx);
      case (idx)
         0:       return 8'h7E;  // 127 columns per line
         1:       return 8'h50;  // 80 displayed
         2:       return 8'h66;
         3:       return 8'h49;  // vsync 4 lines, hsync 9 columns
         4:       return 8'h20;
         5:       return 8'hE0;  // no adjust lines
         6:       return 8'h19;  // 25 rows
         7:       return 8'h1D;
         8:       return 8'hFC;
         9:       return 8'hE7;  // 8 lines per row
         10:      return 8'hA0;  // cursor off
         11:      return 8'hE7;
         20:      return 8'h08;
         22:      return 8'h78;  // 8 dots per column
         23:      return 8'hE8;
         24:      return 8'h20;
         25:      return 8'h47;
         26:      return 8'hF0;  // white on black
         29:      return 8'hE7;
         34:      return 8'h7D;
         35:      return 8'h64;
         36:      return 8'hF5;
         default: return 8'h00;
      endcase
   endfunction

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `VDC_REG_COUNT; i++)
            regs[i] <= resetVal(i);
         init <= 1'b0;
      end else begin
         if (regWr && regIdx < `VDC_REG_COUNT)
            regs[regIdx] <= regWrData;
         // raster restarts after any geometry change
         init <= regWr && (regIdx == idxHt || regIdx == idxVt ||
                           regIdx == idxCtv || regIdx == idxCharH);
      end
   end

   assign regRdData = (regIdx < `VDC_REG_COUNT) ? regs[regIdx] : 8'hFF;  // unused reads high

   assign ht         = regs[idxHt];
   assign hd         = regs[idxHd];
   assign hp         = regs[idxHp];
   assign hw         = regs[idxSync][3:0];
   assign vw         = regs[idxSync][7:4];
   assign vt         = regs[idxVt];
   assign va         = regs[idxVa][4:0];
   assign vd         = regs[idxVd];
   assign vp         = regs[idxVp];
   assign ctv        = regs[idxCtv][4:0];
   assign cursorMode = regs[idxCurMode][6:5];
   assign dispStart  = {regs[idxDispHi], regs[idxDispLo]};
   assign cursorPos  = {regs[idxCurHi], regs[idxCurLo]};
   assign cth        = regs[idxCharH][7:4];  // low nibble, displayed width, not used here
   assign fg         = regs[idxColor][7:4];
   assign bg         = regs[idxColor][3:0];
   assign deb        = regs[idxDeb];
   assign dee        = regs[idxDee];

   // a CPU write never targets a register beyond the implemented set
   aRegIdxRange: assert property (@(posedge clk) disable iff (!rstN)
      regWr |-> regIdx < `VDC_REG_COUNT);

endmodule

//--- vdcTiming.sv
/*
 * VDC raster timing
 * dot, column, scan line and row counters with vertical adjust,
 * sync and blank generation and the two cursor blink dividers
 */

`timescale 1ns/1ps
`include "vdc_params.svh"

module vdcTiming
   import vdcRegPkg::*;
   import vdcVideoPkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       init,
   input  logic       dotEn,
   input  regByteT    ht, hd, hp, vt, vd, vp, deb, dee,
   input  logic [3:0] hw, vw, cth,
   input  charDimT    va, ctv,
   output frameKindT  newFrame,
   output logic       newRow,
   output logic       newLine,
   output logic       newCol,
   output logic       endCol,
   output colCntT     col,
   output charDimT    line,
   output logic [1:0] visible,
   output logic [1:0] blink,
   output logic       hsync,
   output logic       vsync,
   output logic       hblank,
   output logic       vblank
);

   localparam int blinkHalf [2] = '{`VDC_BLINK_FAST, `VDC_BLINK_SLOW};

   logic [3:0]      pixel;     // dots left in the column, 0 starts the next one
   rowCntT          row;
   logic [4:0]      adjust;    // adjust lines still to run
   logic [3:0]      hsCount;   // hsync columns left
   logic [4:0]      vsCount;   // vsync lines left
   logic            visLine;
   logic            visCol;
   logic [1:0][4:0] blinkCnt;

   logic       colStep, lineEnd, rowEnd, frameStart, vsStart;
   colCntT     colNext;
   rowCntT     rowInc;
   logic [4:0] vsWidth;

   assign colStep    = dotEn && pixel == 4'd0;
   assign lineEnd    = colStep && col == ht;
   assign rowEnd     = lineEnd && adjust == 5'd0 && line == ctv;
   assign frameStart = lineEnd && (adjust == 5'd1 ||
                       (rowEnd && row == vt && va == 5'd0));  // adjust done or none asked
   assign colNext    = (col == ht) ? 8'd0 : col + 8'd1;
   assign rowInc     = row + 8'd1;
   assign vsWidth    = (vw == 4'd0) ? 5'd16 : {1'b0, vw};      // 0 codes 16 lines
   assign vsStart    = frameStart ? vp == 8'd0
                                  : rowEnd && row != vt && rowInc == vp;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pixel    <= '0;
         col      <= '0;
         line     <= '0;
         row      <= '0;
         adjust   <= '0;
         hsCount  <= '0;
         vsCount  <= '0;
         visLine  <= 1'b1;
         visCol   <= 1'b1;
         hblank   <= 1'b0;
         newFrame <= FRAME_NONE;
         newRow   <= 1'b0;
         newLine  <= 1'b0;
         newCol   <= 1'b0;
         endCol   <= 1'b0;
      end else if (init) begin
         pixel    <= cth;    // restart inside column 0 of row 0
         col      <= '0;
         line     <= '0;
         row      <= '0;
         adjust   <= '0;
         hsCount  <= '0;
         vsCount  <= '0;
         visLine  <= 1'b1;
         visCol   <= 1'b1;
         hblank   <= 1'b0;
         newFrame <= FRAME_NONE;
         newRow   <= 1'b0;
         newLine  <= 1'b0;
         newCol   <= 1'b0;
         endCol   <= 1'b0;
      end else begin
         // pulses last one clock whatever dotEn does next
         newFrame <= FRAME_NONE;
         newRow   <= 1'b0;
         newLine  <= 1'b0;
         newCol   <= 1'b0;
         endCol   <= 1'b0;

         if (dotEn) begin
            pixel <= pixel - 4'd1;
            if (cth == 4'd0 || pixel == 4'd1)
               endCol <= 1'b1;  // last dot of the column
         end

         if (colStep) begin
            newCol <= 1'b1;
            pixel  <= cth;
            col    <= colNext;
            visCol <= colNext < hd;
            if (colNext == hp)
               hsCount <= hw;  // hw of 0 gives no hsync
            else if (|hsCount)
               hsCount <= hsCount - 4'd1;
            // blank window, begin wins when both match
            if (colNext == dee) hblank <= 1'b1;
            if (colNext == deb) hblank <= 1'b0;
         end

         if (lineEnd) begin
            newLine <= 1'b1;
            line    <= line + 5'd1;  // keeps counting through adjust
            if (|adjust)
               adjust <= adjust - 5'd1;
            if (vsStart)
               vsCount <= vsWidth;
            else if (|vsCount)
               vsCount <= vsCount - 5'd1;
         end

         if (rowEnd) begin
            newRow  <= 1'b1;
            line    <= '0;
            row     <= rowInc;
            visLine <= row != vt && rowInc < vd;
            if (row == vt)
               adjust <= va;  // nonzero va holds the frame start back
         end

         if (frameStart) begin
            newFrame <= FRAME_SINGLE;  // interlace not handled
            row      <= '0;
            line     <= '0;
            visLine  <= vd != 8'd0;
         end
      end
   end

   // blink dividers, count frame starts
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         blink    <= '0;
         blinkCnt <= '0;
      end else if (init) begin
         blink    <= '0;
         blinkCnt <= '0;
      end else if (newFrame != FRAME_NONE) begin
         for (int i = 0; i < 2; i++) begin
            if (blinkCnt[i] == 5'(blinkHalf[i] - 1)) begin
               blink[i]    <= ~blink[i];
               blinkCnt[i] <= '0;
            end else begin
               blinkCnt[i] <= blinkCnt[i] + 5'd1;
            end
         end
      end
   end

   assign visible = {visCol, visLine};  // 11 = displayed cell
   assign hsync   = |hsCount;
   assign vsync   = |vsCount;
   assign vblank  = ~visLine;

   // a column of one dot is the only case where first and last dot coincide
   aColEdges: assert property (@(posedge clk) disable iff (!rstN)
      (newCol && endCol) |-> cth == 4'd0);

endmodule

//--- vdcAddrGen.sv
/*
 * VDC screen address generator
 * walks the screen memory one cell per displayed column, row by row
 * from the display start, and flags the cursor cell
 */

`timescale 1ns/1ps

module vdcAddrGen
   import vdcRegPkg::*;
   import vdcVideoPkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  frameKindT  newFrame,
   input  logic       newRow,
   input  logic       newCol,
   input  logic [1:0] visible,
   input  scrAddrT    dispStart,
   input  scrAddrT    cursorPos,
   input  regByteT    hd,
   output scrAddrT    memAddr,
   output logic       cursorHit
);

   scrAddrT rowStart;   // first cell of the current row
   scrAddrT runAddr;    // next cell on this line
   scrAddrT base;       // line start seen at this cycle
   scrAddrT cellAddr;
   logic    lineReload;

   assign lineReload = newFrame != FRAME_NONE || newRow;
   // frame start wins over the row step that comes with it
   assign base     = (newFrame != FRAME_NONE) ? dispStart
                   : newRow ? rowStart + scrAddrT'(hd)
                   : rowStart;
   assign cellAddr = lineReload ? base : runAddr;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rowStart  <= '0;
         runAddr   <= '0;
         memAddr   <= '0;
         cursorHit <= 1'b0;
      end else begin
         if (lineReload)
            rowStart <= base;
         if (newCol) begin
            if (visible == 2'b11) begin
               memAddr   <= cellAddr;  // data due by the next newCol
               runAddr   <= cellAddr + 16'd1;
               cursorHit <= cellAddr == cursorPos;
            end else begin
               runAddr   <= base;      // rewind in the border for the next line
               cursorHit <= 1'b0;
            end
         end
      end
   end

endmodule

//--- vdcVideoOut.sv
/*
 * VDC pixel output
 * shifts the cell byte out MSB first at the dot rate, applies fg/bg,
 * cursor inversion and blanking to give RGBI
 */

`timescale 1ns/1ps

module vdcVideoOut
   import vdcVideoPkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       dotEn,
   input  logic       newCol,
   input  logic [1:0] visible,
   input  logic       cursorHit,
   input  logic       hblank,
   input  logic       vblank,
   input  logic [1:0] blink,
   input  logic [1:0] cursorMode,
   input  rgbiT       fg,
   input  rgbiT       bg,
   input  logic [7:0] charBits,
   output rgbiT       rgbi
);

   logic [7:0] shiftReg;
   logic [1:0] visPrev;     // visibility of the column being fetched
   logic       cellVis;     // the cell now shifting out is displayed
   logic       cellInv;
   logic [7:0] curBits;
   logic       curVis, curInv, curOn;

   // solid, off, fast blink, slow blink
   always_comb begin
      case (cursorMode)
         2'd0:    curOn = 1'b1;
         2'd1:    curOn = 1'b0;
         2'd2:    curOn = blink[0];
         default: curOn = blink[1];
      endcase
   end

   // a dot on the load cycle already takes the new cell
   assign curBits = newCol ? charBits : shiftReg;
   assign curVis  = newCol ? visPrev == 2'b11 : cellVis;
   assign curInv  = newCol ? cursorHit && curOn : cellInv;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
         shiftReg <= '0;
      else if (dotEn)
         shiftReg <= {curBits[6:0], 1'b0};
      else if (newCol)
         shiftReg <= charBits;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         visPrev <= '0;
         cellVis <= 1'b0;
         cellInv <= 1'b0;
         rgbi    <= '0;
      end else begin
         if (newCol) begin
            visPrev <= visible;
            cellVis <= curVis;
            cellInv <= curInv;
         end
         if (dotEn) begin
            if (hblank || vblank)
               rgbi <= '0;
            else if (!curVis)
               rgbi <= bg;  // border
            else
               rgbi <= (curBits[7] ^ curInv) ? fg : bg;
         end
      end
   end

endmodule

//--- vdcVideo.sv
/*
 * VDC video path top level
 * register file, raster timing, screen address and pixel output
 * chained into the four stage display pipeline
 */

`timescale 1ns/1ps

module vdcVideo
   import vdcRegPkg::*;
   import vdcVideoPkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       regWr,
   input  regIdxT     regIdx,
   input  regByteT    regWrData,
   output regByteT    regRdData,
   input  logic       dotEn,
   output scrAddrT    memAddr,
   input  logic [7:0] charBits,
   output rgbiT       rgbi,
   output logic       hsync,
   output logic       vsync,
   output logic       hblank,
   output logic       vblank,
   output frameKindT  newFrame
);

   regByteT    ht, hd, hp, vt, vd, vp, deb, dee;
   logic [3:0] hw, vw, cth, fg, bg;
   charDimT    va, ctv;
   scrAddrT    dispStart, cursorPos;
   logic [1:0] cursorMode;
   logic       init;

   logic       newRow, newLine, newCol, endCol;
   colCntT     col;
   charDimT    line;
   logic [1:0] visible, blink;
   logic       cursorHit;

   vdcRegFile uRegFile (
      .clk, .rstN, .regWr, .regIdx, .regWrData, .regRdData,
      .ht, .hd, .hp, .vt, .vd, .vp, .deb, .dee,
      .hw, .vw, .cth, .fg, .bg, .va, .ctv,
      .dispStart, .cursorPos, .cursorMode, .init
   );

   vdcTiming uTiming (
      .clk, .rstN, .init, .dotEn,
      .ht, .hd, .hp, .vt, .vd, .vp, .deb, .dee, .hw, .vw, .cth, .va, .ctv,
      .newFrame, .newRow, .newLine, .newCol, .endCol, .col, .line,
      .visible, .blink, .hsync, .vsync, .hblank, .vblank
   );

   vdcAddrGen uAddrGen (
      .clk, .rstN, .newFrame, .newRow, .newCol, .visible,
      .dispStart, .cursorPos, .hd, .memAddr, .cursorHit
   );

   vdcVideoOut uVideoOut (
      .clk, .rstN, .dotEn, .newCol, .visible, .cursorHit, .hblank, .vblank,
      .blink, .cursorMode, .fg, .bg, .charBits, .rgbi
   );

endmodule

//--- vdcVideoTb.sv
/*
 * VDC video path testbench
 * table driven register setups, a screen memory model and reference
 * raster counters that predict pulses, syncs, blanks and pixels
 */

`timescale 1ns/1ps

module vdcVideoTb
   import vdcRegPkg::*;
   import vdcVideoPkg::*;
();

   localparam int dispCols = 8;  // R1
   localparam int dispRows = 3;  // R6
   localparam int blankCol = 8;  // R35, R34 is 0
   localparam rgbiT fgCol = 4'hE;
   localparam rgbiT bgCol = 4'h1;

   typedef struct {
      int ht, cth, vt, ctv, va, hp, hw, vp, vw, cursor, mode, frames;
      int expDots, expLines;  // (ht+1)(cth+1) and (vt+1)(ctv+1)+va
   } caseT;

   logic clk, rstN, regWr, dotEn, hsync, vsync, hblank, vblank;
   regIdxT regIdx;
   regByteT regWrData, regRdData;
   scrAddrT memAddr, rowStart, expAddr;
   logic [7:0] charBits, refBits, prevByte;
   rgbiT rgbi, expRgbi;
   frameKindT newFrame;
   logic [31:0] rngState;
   caseT tbl [4];

   // reference raster state
   int refCol, refRow, refVs, refFrames, dotsInLine, linesInFrame, framesSeen, framesCyc;
   logic lineArmed, synced, pendChk, addrPend, prevVis, prevHit, refCellVis, refInv;

   vdcVideo u_dut (
      .clk, .rstN, .regWr, .regIdx, .regWrData, .regRdData, .dotEn,
      .memAddr, .charBits, .rgbi, .hsync, .vsync, .hblank, .vblank, .newFrame
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic writeReg(input int idx, input int data);
      dotEn = 1'b0;  // raster parked while the CPU writes
      @(negedge clk);
      regIdx    = regIdxT'(idx);
      regWrData = regByteT'(data);
      regWr     = 1'b1;
      @(negedge clk);
      regWr = 1'b0;
      checkVal("regRdData", regWrData, regRdData);  // readback, same index
   endtask

   task automatic readDefault(input int idx, input int data);
      @(negedge clk);
      regIdx = regIdxT'(idx);
      #1;
      checkVal("regRdData default", data, regRdData);
   endtask

   // one clock of the reference model, run on the falling edge
   task automatic stepCycle(input caseT c);
      logic nf, nr, nl, nc, vis, on;
      scrAddrT addr;
      @(negedge clk);
      if (pendChk)
         checkVal("rgbi", expRgbi, rgbi);
      if (addrPend)
         checkVal("memAddr", expAddr, memAddr);  // fetch one clock after newCol
      pendChk = 1'b0;
      addrPend = 1'b0;
      nf = newFrame != FRAME_NONE;
      nr = u_dut.newRow;
      nl = u_dut.newLine;
      nc = u_dut.newCol;
      if (nl) begin
         if (lineArmed) checkVal("dots per line", c.expDots, dotsInLine);
         lineArmed = 1'b1;
         dotsInLine = 0;
         linesInFrame++;  // the line closing a frame belongs to it
      end
      if (nf) begin
         checkVal("newFrame", FRAME_SINGLE, newFrame);  // progressive only
         if (synced) checkVal("lines per frame", c.expLines, linesInFrame);
         synced = 1'b1;
         linesInFrame = 0;
         framesSeen++;
         framesCyc = 0;
      end
      if (nc) begin
         case (c.mode)
            0: on = 1'b1;
            1: on = 1'b0;
            2: on = (refFrames / 16) % 2;  // fast blink
            default: on = (refFrames / 30) % 2;
         endcase
         refBits    = prevByte;  // cell fetched during the last column
         refCellVis = prevVis;
         refInv     = prevHit && on;
      end
      if (nf) begin
         refRow = 0;
         rowStart = '0;  // display start R12/R13
      end else if (nr) begin
         refRow++;
         rowStart = rowStart + dispCols;
      end
      if (nl) begin
         if ((nf || nr) && refRow == c.vp)
            refVs = (c.vw == 0) ? 16 : c.vw;
         else if (refVs > 0)
            refVs--;
         if (synced) begin
            checkVal("vsync", refVs != 0, vsync);
            checkVal("vblank", refRow >= dispRows, vblank);
         end
      end
      if (nc) begin
         refCol   = (refCol == c.ht) ? 0 : refCol + 1;
         vis      = refCol < dispCols && refRow < dispRows;
         addr     = rowStart + scrAddrT'(refCol);
         prevVis  = vis;
         prevByte = addr[7:0] ^ 8'hA5;  // what the memory model returns
         prevHit  = vis && addr == scrAddrT'(c.cursor);
         expAddr  = addr;
         addrPend = synced && vis;
         if (synced) begin
            checkVal("hsync", refCol >= c.hp && refCol < c.hp + c.hw, hsync);
            checkVal("hblank", refCol >= blankCol, hblank);
         end
      end
      if (nf) refFrames++;  // blink moves after the frame pulse
      rngState = xorshift(rngState);
      dotEn = rngState[1:0] != 2'b00;  // about three dots in four clocks
      if (dotEn) begin
         if (refCol >= blankCol || refRow >= dispRows)
            expRgbi = '0;
         else if (!refCellVis)
            expRgbi = bgCol;  // border
         else
            expRgbi = (refBits[7] ^ refInv) ? fgCol : bgCol;
         refBits = refBits << 1;
         pendChk = synced;
         dotsInLine++;
      end
      charBits = memAddr[7:0] ^ 8'hA5;
      framesCyc++;
      if (framesCyc > 4000) begin
         $display("timeout: newFrame pulse never came within 4000 clocks");
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   initial begin
      clk = 1'b0;
      rstN = 1'b0;
      regWr = 1'b0;
      regIdx = '0;
      regWrData = '0;
      dotEn = 1'b0;
      charBits = '0;
      rngState = 32'd4417;
      pendChk = 1'b0;
      addrPend = 1'b0;
      //         ht cth vt ctv va hp hw vp vw cur md frm dots lines
      tbl[0] = '{9, 3, 3, 3, 0, 5, 3, 1, 2, 10, 0, 3, 40, 16};
      tbl[1] = '{11, 2, 5, 3, 2, 7, 2, 2, 0, 9, 1, 3, 36, 26};
      tbl[2] = '{9, 3, 3, 3, 0, 5, 3, 1, 2, 10, 2, 34, 40, 16};
      tbl[3] = '{9, 3, 3, 3, 0, 5, 3, 1, 2, 10, 3, 34, 40, 16};
      repeat (3) @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);
      checkVal("rgbi", 0, rgbi);  // quiet outputs after reset
      checkVal("hsync", 0, hsync);
      checkVal("vsync", 0, vsync);
      checkVal("hblank", 0, hblank);
      checkVal("vblank", 0, vblank);
      checkVal("newFrame", FRAME_NONE, newFrame);
      readDefault(8, 8'hFC);
      readDefault(11, 8'hE7);
      readDefault(20, 8'h08);
      readDefault(36, 8'hF5);
      writeReg(1, dispCols);
      writeReg(6, dispRows);
      writeReg(12, 0);
      writeReg(13, 0);
      writeReg(26, {fgCol, bgCol});
      writeReg(34, 0);
      writeReg(35, blankCol);
      for (int i = 0; i < 4; i++) begin
         writeReg(2, tbl[i].hp);
         writeReg(3, tbl[i].vw * 16 + tbl[i].hw);
         writeReg(5, tbl[i].va);
         writeReg(7, tbl[i].vp);
         writeReg(10, tbl[i].mode * 32);
         writeReg(14, tbl[i].cursor / 256);
         writeReg(15, tbl[i].cursor % 256);
         writeReg(4, tbl[i].vt);
         writeReg(9, tbl[i].ctv);
         writeReg(22, tbl[i].cth * 16 + 8);
         writeReg(0, tbl[i].ht);  // last init restarts the raster
         @(negedge clk);
         refCol = 0;
         refRow = 0;
         refVs = 0;
         refFrames = 0;
         dotsInLine = 0;
         linesInFrame = 0;
         framesSeen = 0;
         framesCyc = 0;
         rowStart = '0;
         lineArmed = 1'b0;
         synced = 1'b0;
         pendChk = 1'b0;
         addrPend = 1'b0;
         prevVis = 1'b0;
         prevHit = 1'b0;
         prevByte = '0;
         refBits = '0;
         refCellVis = 1'b0;
         refInv = 1'b0;
         while (framesSeen < tbl[i].frames)
            stepCycle(tbl[i]);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

//--- vdcVideo.f
+incdir+.
vdcRegPkg.sv
vdcVideoPkg.sv
vdcRegFile.sv
vdcTiming.sv
vdcAddrGen.sv
vdcVideoOut.sv
vdcVideo.sv
vdcVideoTb.sv
